// ==== hw/tlu_pkg.sv ====
// tlu controller package: mode and state enums, timing constants, packed structs

package tlu_pkg;

    // widths
    localparam int WORD_W    = 32; // timestamp, counter, data word
    localparam int TIMEOUT_W = 8;  // low timeout setting and wait counters

    // glitch filter on the TLU trigger line, high cycles before acceptance
    localparam int ACCEPT_WAIT_CYCLES = 5;

    // idle cycles after a trigger before veto may be raised again
    localparam int HANDSHAKE_VETO_WAIT_CYCLES = 5;

    typedef enum logic [1:0] {
        MODE_SIMPLE     = 2'b00,
        MODE_SIMPLE_ALT = 2'b01, // same as simple
        MODE_HANDSHAKE  = 2'b10,
        MODE_RESERVED   = 2'b11  // never starts a trigger
    } tlu_mode_e;

    typedef enum logic [2:0] {
        IDLE             = 3'd0,
        SEND_COMMAND     = 3'd1,
        WAIT_TRIGGER_LOW = 3'd2,
        LATCH_DATA       = 3'd3,
        WAIT_ACK         = 3'd4
    } trig_state_e;

    typedef struct packed {
        tlu_mode_e              mode;
        logic [TIMEOUT_W-1:0]   low_time_out; // 0 disables the timeout
        logic                   enable_veto;
    } tlu_cfg_t;

    // one-cycle strobes from the trigger FSM
    typedef struct packed {
        logic accepted;
        logic write;
    } trig_event_t;

    typedef struct packed {
        logic [WORD_W-1:0] timestamp;
        logic [WORD_W-1:0] trigger_count;
    } count_snap_t;

endpackage

// ==== hw/tlu_trigger_fsm.sv ====
// trigger FSM: glitch filter, low timeout, veto hold-off, sticky acknowledge, error flags

module tlu_trigger_fsm
    import tlu_pkg::*;
(
    input  logic        TRIGGER_CLK,
    input  logic        RESET,
    input  tlu_cfg_t    cfg,
    input  logic        trigger,
    input  logic        trigger_flag,
    input  logic        trigger_veto,
    input  logic        trigger_enable,
    input  logic        trigger_acknowledge,
    output trig_event_t events,
    output logic        busy,
    output logic        assert_veto,
    output logic        accept_error,
    output logic        low_timeout_error
);

    trig_state_e          state;
    trig_state_e          next_state;
    logic                 is_simple;
    logic                 is_handshake;
    logic                 entering;
    logic                 handshake_accept; // trigger passed the glitch filter
    logic                 acknowledged;     // ack seen since acceptance
    logic [TIMEOUT_W-1:0] high_cnt;
    logic [TIMEOUT_W-1:0] low_cnt;
    logic [TIMEOUT_W-1:0] veto_cnt;

    assign is_simple    = (cfg.mode == MODE_SIMPLE) || (cfg.mode == MODE_SIMPLE_ALT);
    assign is_handshake = (cfg.mode == MODE_HANDSHAKE);
    assign entering     = (state != next_state);

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (trigger_enable && !trigger_acknowledge)
                begin
                    if (is_simple && trigger_flag && !trigger_veto)
                        next_state = SEND_COMMAND;
                    else if (is_handshake && handshake_accept)
                        next_state = WAIT_TRIGGER_LOW;
                end
            end
            SEND_COMMAND:
                next_state = LATCH_DATA; // flag trigger, no wait for low
            WAIT_TRIGGER_LOW:
            begin
                if (!trigger || low_timeout_error)
                    next_state = LATCH_DATA;
            end
            LATCH_DATA:
                next_state = WAIT_ACK;
            WAIT_ACK:
            begin
                if (trigger_acknowledge || acknowledged)
                    next_state = IDLE;
            end
            default:
                next_state = IDLE;
        endcase
    end

    // outputs registered from the next state
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            state             <= IDLE;
            events            <= '0;
            busy              <= 1'b0;
            assert_veto       <= 1'b0;
            accept_error      <= 1'b0;
            low_timeout_error <= 1'b0;
            handshake_accept  <= 1'b0;
            acknowledged      <= 1'b0;
            high_cnt          <= '0;
            low_cnt           <= '0;
            veto_cnt          <= '0;
        end
        else
        begin
            state             <= next_state;
            events            <= '0;
            busy              <= (next_state != IDLE);
            assert_veto       <= 1'b0;
            accept_error      <= 1'b0;
            low_timeout_error <= 1'b0;
            handshake_accept  <= 1'b0;
            acknowledged      <= acknowledged | trigger_acknowledge;
            high_cnt          <= '0;
            low_cnt           <= '0;

            case (next_state)
                IDLE:
                begin
                    acknowledged <= 1'b0;
                    // only toward the TLU outside the trigger/busy handshake
                    assert_veto <= cfg.enable_veto && is_handshake && (veto_cnt == '0)
                                   && (!trigger_enable || trigger_veto);
                    if (trigger && is_handshake && trigger_enable)
                        high_cnt <= (high_cnt == '1) ? high_cnt : high_cnt + 1'b1;
                    // still high on this edge as well
                    handshake_accept <= trigger
                                        && (high_cnt >= TIMEOUT_W'(ACCEPT_WAIT_CYCLES));
                    // trigger dropped before it was accepted
                    accept_error <= (high_cnt != '0) && !trigger && is_handshake
                                    && trigger_enable;
                    if (entering)
                        veto_cnt <= TIMEOUT_W'(HANDSHAKE_VETO_WAIT_CYCLES);
                    else if (veto_cnt != '0)
                        veto_cnt <= veto_cnt - 1'b1;
                end
                SEND_COMMAND:
                    events.accepted <= entering;
                WAIT_TRIGGER_LOW:
                begin
                    events.accepted <= entering;
                    low_cnt <= (low_cnt == '1) ? low_cnt : low_cnt + 1'b1;
                    low_timeout_error <= (cfg.low_time_out != '0)
                                         && (low_cnt >= cfg.low_time_out);
                end
                LATCH_DATA:
                    events.write <= 1'b1;
                default:
                begin
                end
            endcase
        end
    end

    a_accept_write_excl: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        !(events.accepted && events.write));

    a_write_busy: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        events.write |-> busy);

    a_state_legal: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        state inside {IDLE, SEND_COMMAND, WAIT_TRIGGER_LOW, LATCH_DATA, WAIT_ACK});

endmodule

// ==== hw/tlu_event_counters.sv ====
// event counters: free-running timestamp with clear, loadable trigger counter

module tlu_event_counters
    import tlu_pkg::*;
(
    input  logic              TRIGGER_CLK,
    input  logic              RESET,
    input  logic              timestamp_clear,
    input  logic              counter_set,
    input  logic [WORD_W-1:0] counter_set_value,
    input  logic              accepted,
    output count_snap_t       counts
);

    logic [WORD_W-1:0] timestamp;
    logic [WORD_W-1:0] trigger_count;

    // timestamp runs every cycle
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || timestamp_clear)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trigger_count <= '0;
        else if (counter_set)
            trigger_count <= counter_set_value; // load wins over count
        else if (accepted)
            trigger_count <= trigger_count + 1'b1;
    end

    assign counts = '{timestamp: timestamp, trigger_count: trigger_count};

    // a load is visible on the next cycle
    a_counter_load: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        counter_set |=> (counts.trigger_count == $past(counter_set_value)));

endmodule

// ==== hw/tlu_trigger_word.sv ====
// trigger word builder: counter snapshot at acceptance, marked 32-bit data word

module tlu_trigger_word
    import tlu_pkg::*;
(
    input  logic              TRIGGER_CLK,
    input  logic              RESET,
    input  trig_event_t       events,
    input  count_snap_t       counts,
    input  logic              write_timestamp,
    output logic              data_write,
    output logic [WORD_W-1:0] trigger_data
);

    count_snap_t snap;

    // counts as seen in the accepted cycle, before the counter increments
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            snap <= '0;
        else if (events.accepted)
            snap <= counts;
    end

    assign data_write = events.write;

    // bit 31 marks a trigger word
    always_comb
    begin
        if (write_timestamp)
            trigger_data = {1'b1, snap.timestamp[WORD_W-2:0]};
        else
            trigger_data = {1'b1, snap.trigger_count[WORD_W-2:0]};
    end

    a_word_marked: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        data_write |-> trigger_data[WORD_W-1]);

endmodule

// ==== hw/tlu_controller.sv ====
// tlu controller top: trigger FSM and event counters side by side, word builder on top

module tlu_controller
    import tlu_pkg::*;
(
    input  logic              TRIGGER_CLK,
    input  logic              RESET,
    input  tlu_cfg_t          cfg,
    input  logic              trigger,             // TLU trigger line
    input  logic              trigger_flag,        // one-cycle flag, simple mode
    input  logic              trigger_veto,
    input  logic              trigger_enable,
    input  logic              trigger_acknowledge,
    input  logic              write_timestamp,     // level, word carries timestamp
    input  logic              timestamp_clear,
    input  logic              counter_set,
    input  logic [WORD_W-1:0] counter_set_value,
    output logic              busy,
    output logic              assert_veto,
    output logic              accept_error,
    output logic              low_timeout_error,
    output logic              accepted_flag,
    output logic              data_write,
    output logic [WORD_W-1:0] trigger_data
);

    trig_event_t events;
    count_snap_t counts;

    tlu_trigger_fsm u_fsm (
        .TRIGGER_CLK         (TRIGGER_CLK),
        .RESET               (RESET),
        .cfg                 (cfg),
        .trigger             (trigger),
        .trigger_flag        (trigger_flag),
        .trigger_veto        (trigger_veto),
        .trigger_enable      (trigger_enable),
        .trigger_acknowledge (trigger_acknowledge),
        .events              (events),
        .busy                (busy),
        .assert_veto         (assert_veto),
        .accept_error        (accept_error),
        .low_timeout_error   (low_timeout_error)
    );

    tlu_event_counters u_counters (
        .TRIGGER_CLK       (TRIGGER_CLK),
        .RESET             (RESET),
        .timestamp_clear   (timestamp_clear),
        .counter_set       (counter_set),
        .counter_set_value (counter_set_value),
        .accepted          (events.accepted),
        .counts            (counts)
    );

    tlu_trigger_word u_word (
        .TRIGGER_CLK     (TRIGGER_CLK),
        .RESET           (RESET),
        .events          (events),
        .counts          (counts),
        .write_timestamp (write_timestamp),
        .data_write      (data_write),
        .trigger_data    (trigger_data)
    );

    assign accepted_flag = events.accepted;

endmodule

// ==== dv/tlu_controller_tb.sv ====
// testbench for the tlu controller: clock, reset, stimulus table, reference model, checks, watchdog

module tlu_controller_tb
    import tlu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          N_ENTRIES  = 17;
    localparam int          MAX_CYCLES = N_ENTRIES * 60;
    localparam int          WRITE_WAIT = 40; // cycles to wait for a data write
    localparam logic [31:0] SEED       = 32'h87f8_1cf6;

    typedef struct packed {
        tlu_mode_e   mode;
        logic [7:0]  pulse_len;    // 0 gives a one-cycle flag
        logic        veto;
        logic        enable;
        logic        enable_veto;
        logic [7:0]  low_time_out;
        logic        ack;          // acknowledge at the end of the entry
        logic        wts;
        logic        set_en;
        logic [31:0] set_value;
        logic        ts_clear;
        logic [1:0]  exp_acc;
        logic [1:0]  exp_err;
        logic [1:0]  exp_to;
        logic [1:0]  exp_wr_hi;    // writes while trigger still high
        logic        exp_veto;
    } entry_t;

    logic              TRIGGER_CLK;
    logic              RESET;
    tlu_cfg_t          cfg;
    logic              trigger;
    logic              trigger_flag;
    logic              trigger_veto;
    logic              trigger_enable;
    logic              trigger_acknowledge;
    logic              write_timestamp;
    logic              timestamp_clear;
    logic              counter_set;
    logic [WORD_W-1:0] counter_set_value;
    logic              busy;
    logic              assert_veto;
    logic              accept_error;
    logic              low_timeout_error;
    logic              accepted_flag;
    logic              data_write;
    logic [WORD_W-1:0] trigger_data;

    entry_t            tbl [N_ENTRIES];
    logic [WORD_W-1:0] ts_model;
    logic [WORD_W-1:0] cnt_model;
    logic [WORD_W-1:0] snap_ts;
    logic [WORD_W-1:0] snap_cnt;
    logic              pending;  // busy expected
    logic              written;  // write seen since acceptance
    logic              acc_prev;
    logic              to_prev;
    int                acc_n;
    int                err_n;
    int                to_n;
    int                wr_n;
    int                wr_hi_n;
    int                veto_n;
    int                n_checks = 0;
    int                n_errors = 0;
    int                cycles = 0;

    tlu_controller UUT (
        .TRIGGER_CLK         (TRIGGER_CLK),
        .RESET               (RESET),
        .cfg                 (cfg),
        .trigger             (trigger),
        .trigger_flag        (trigger_flag),
        .trigger_veto        (trigger_veto),
        .trigger_enable      (trigger_enable),
        .trigger_acknowledge (trigger_acknowledge),
        .write_timestamp     (write_timestamp),
        .timestamp_clear     (timestamp_clear),
        .counter_set         (counter_set),
        .counter_set_value   (counter_set_value),
        .busy                (busy),
        .assert_veto         (assert_veto),
        .accept_error        (accept_error),
        .low_timeout_error   (low_timeout_error),
        .accepted_flag       (accepted_flag),
        .data_write          (data_write),
        .trigger_data        (trigger_data)
    );

    always #10 TRIGGER_CLK = ~TRIGGER_CLK;

    always @(posedge TRIGGER_CLK)
    begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        n_checks++;
        assert (got === exp)
        else
        begin
            $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            n_errors++;
        end
    endtask

    // one falling edge, then the reference model and the per-cycle checks
    task automatic sample_cycle();
        logic [WORD_W-1:0] exp_word;
        @(negedge TRIGGER_CLK);
        // inputs still hold what the last rising edge sampled
        if (RESET || timestamp_clear)
            ts_model = '0;
        else
            ts_model = ts_model + 1;
        if (RESET)
            cnt_model = '0;
        else if (counter_set)
            cnt_model = counter_set_value;
        if (trigger_acknowledge && written)
        begin
            pending = 1'b0;
            written = 1'b0;
        end
        if (accepted_flag)
        begin
            acc_n++;
            pending = 1'b1;
            snap_ts = ts_model;
            snap_cnt = cnt_model;
            cnt_model = cnt_model + 1; // counter steps at the next edge
        end
        if (data_write)
        begin
            wr_n++;
            written = 1'b1;
            if (trigger)
                wr_hi_n++;
            exp_word = {1'b1, (write_timestamp ? snap_ts[30:0] : snap_cnt[30:0])};
            check_eq(trigger_data, exp_word, "trigger word");
        end
        if (cfg.mode == MODE_SIMPLE || cfg.mode == MODE_SIMPLE_ALT)
            check_eq(32'(data_write), 32'(acc_prev), "write one cycle after accept");
        if (cfg.mode == MODE_HANDSHAKE && data_write)
            check_eq(32'(!trigger || to_prev), 32'd1, "write after trigger low or timeout");
        check_eq(32'(busy), 32'(pending), "busy level");
        if (accept_error)
            err_n++;
        if (low_timeout_error)
            to_n++;
        if (assert_veto)
            veto_n++;
        acc_prev = accepted_flag;
        to_prev = low_timeout_error;
    endtask

    task automatic run_entry(input int idx);
        entry_t e;
        int     waited;
        e = tbl[idx];
        acc_n = 0;
        err_n = 0;
        to_n = 0;
        wr_n = 0;
        wr_hi_n = 0;
        veto_n = 0;
        cfg = '{mode: e.mode, low_time_out: e.low_time_out, enable_veto: e.enable_veto};
        trigger_veto = e.veto;
        trigger_enable = e.enable;
        write_timestamp = e.wts;
        counter_set = e.set_en;
        counter_set_value = e.set_value;
        timestamp_clear = e.ts_clear;
        sample_cycle();
        counter_set = 1'b0;
        timestamp_clear = 1'b0;
        repeat (6) sample_cycle(); // veto hold-off runs out
        if (e.pulse_len == 0)
        begin
            trigger_flag = 1'b1;
            sample_cycle();
            trigger_flag = 1'b0;
        end
        else
        begin
            trigger = 1'b1;
            repeat (e.pulse_len) sample_cycle();
            trigger = 1'b0;
        end
        waited = 0;
        while (wr_n < int'(e.exp_acc) && waited < WRITE_WAIT)
        begin
            sample_cycle();
            waited++;
        end
        if (e.ack)
        begin
            repeat (1 + $urandom % 4) sample_cycle(); // random ack delay
            trigger_acknowledge = 1'b1;
            sample_cycle();
            trigger_acknowledge = 1'b0;
        end
        repeat (3) sample_cycle();
        check_eq(acc_n, 32'(e.exp_acc), $sformatf("entry %0d accepted pulses", idx));
        check_eq(wr_n, 32'(e.exp_acc), $sformatf("entry %0d data writes", idx));
        check_eq(err_n, 32'(e.exp_err), $sformatf("entry %0d accept errors", idx));
        check_eq(to_n, 32'(e.exp_to), $sformatf("entry %0d low timeouts", idx));
        check_eq(wr_hi_n, 32'(e.exp_wr_hi), $sformatf("entry %0d writes with trigger high", idx));
        check_eq(32'(veto_n != 0), 32'(e.exp_veto), $sformatf("entry %0d veto seen", idx));
    endtask

    initial
    begin
        void'($urandom(SEED));
        TRIGGER_CLK = 1'b0;
        RESET = 1'b1;
        cfg = '0;
        trigger = 1'b0;
        trigger_flag = 1'b0;
        trigger_veto = 1'b0;
        trigger_enable = 1'b0;
        trigger_acknowledge = 1'b0;
        write_timestamp = 1'b0;
        timestamp_clear = 1'b0;
        counter_set = 1'b0;
        counter_set_value = '0;
        ts_model = '0;
        cnt_model = '0;
        snap_ts = '0;
        snap_cnt = '0;
        pending = 1'b0;
        written = 1'b0;
        acc_prev = 1'b0;
        to_prev = 1'b0;
        // mode              len ve en ev lto ak ts st  set cl ac er to hi vt
        tbl[0]  = '{MODE_SIMPLE,      0, 0, 1, 0,  0, 1, 0, 0,   0, 0, 1, 0, 0, 0, 0};
        tbl[1]  = '{MODE_SIMPLE,      0, 0, 1, 0,  0, 1, 0, 0,   0, 0, 1, 0, 0, 0, 0};
        tbl[2]  = '{MODE_SIMPLE_ALT,  0, 0, 1, 0,  0, 1, 0, 0,   0, 0, 1, 0, 0, 0, 0};
        tbl[3]  = '{MODE_SIMPLE,      0, 0, 1, 0,  0, 1, 0, 1, 100, 0, 1, 0, 0, 0, 0};
        tbl[4]  = '{MODE_SIMPLE,      0, 0, 1, 0,  0, 1, 1, 0,   0, 0, 1, 0, 0, 0, 0};
        tbl[5]  = '{MODE_SIMPLE,      0, 0, 1, 0,  0, 1, 1, 0,   0, 0, 1, 0, 0, 0, 0};
        tbl[6]  = '{MODE_SIMPLE,      0, 0, 1, 0,  0, 1, 1, 0,   0, 1, 1, 0, 0, 0, 0};
        tbl[7]  = '{MODE_HANDSHAKE,  10, 0, 1, 1,  0, 1, 0, 0,   0, 0, 1, 0, 0, 0, 0};
        tbl[8]  = '{MODE_HANDSHAKE,   3, 0, 1, 1,  0, 1, 0, 0,   0, 0, 0, 1, 0, 0, 0};
        tbl[9]  = '{MODE_HANDSHAKE,  30, 0, 1, 0, 10, 1, 0, 0,   0, 0, 1, 0, 1, 1, 0};
        tbl[10] = '{MODE_HANDSHAKE,  30, 0, 1, 0,  0, 1, 0, 0,   0, 0, 1, 0, 0, 0, 0};
        tbl[11] = '{MODE_HANDSHAKE,   0, 0, 0, 1,  0, 1, 0, 0,   0, 0, 0, 0, 0, 0, 1};
        tbl[12] = '{MODE_SIMPLE,      0, 1, 1, 0,  0, 1, 0, 0,   0, 0, 0, 0, 0, 0, 0};
        tbl[13] = '{MODE_RESERVED,    0, 0, 1, 0,  0, 1, 0, 0,   0, 0, 0, 0, 0, 0, 0};
        tbl[14] = '{MODE_SIMPLE,      0, 0, 1, 0,  0, 0, 0, 0,   0, 0, 1, 0, 0, 0, 0};
        tbl[15] = '{MODE_SIMPLE,      0, 0, 1, 0,  0, 1, 0, 0,   0, 0, 0, 0, 0, 0, 0};
        tbl[16] = '{MODE_SIMPLE,      0, 0, 1, 0,  0, 1, 0, 0,   0, 0, 1, 0, 0, 0, 0};
        repeat (5) sample_cycle();
        RESET = 1'b0;
        sample_cycle();
        check_eq(32'({busy, assert_veto, accept_error, low_timeout_error, accepted_flag,
                      data_write}), 32'd0, "control outputs after reset");
        for (int i = 0; i < N_ENTRIES; i++)
            run_entry(i);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== tlu_controller.f ====
hw/tlu_pkg.sv
hw/tlu_trigger_fsm.sv
hw/tlu_event_counters.sv
hw/tlu_trigger_word.sv
hw/tlu_controller.sv
dv/tlu_controller_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the tlu controller testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    -f tlu_controller.f \
    --top-module tlu_controller_tb \
    -o sim_tlu
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

sim_output=$(./obj_dir/sim_tlu 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
